// File: hw/bus_ctrl.sv
// ##############################
// Bus controller
//   Registered chip selects
//   DTACK generation per slave
//   Bus protocol assertions
// ##############################

`timescale 1ns/1ps
`default_nettype none

module bus_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    input  main_bus_pkg::bus_req_t    req,
    input  main_bus_pkg::region_hit_t hit,
    input  wire                       map_hit,
    input  wire                       ram_ok,
    input  wire                       sub_ok,
    input  wire                       dec_ok,
    output main_bus_pkg::slave_sel_t  sel,
    output logic                      dtack_n
);

    main_bus_pkg::slave_sel_t next_sel;
    logic                     strobe;
    logic                     fixed_rdy;
    logic                     var_rdy;
    logic                     ready;

    assign strobe = ~&req.dsn;   // Any byte lane active

    always_comb begin
        next_sel      = '0;
        // Work RAM sits at the top of the mem region
        next_sel.rom  = hit[main_bus_pkg::reg_mem] && req.addr[18:17] != 2'b11;
        next_sel.ram  = hit[main_bus_pkg::reg_mem] && req.addr[18:17] == 2'b11 && strobe;
        next_sel.chr  = hit[main_bus_pkg::reg_scr] && req.addr[16];
        next_sel.vram = hit[main_bus_pkg::reg_scr] && !req.addr[16] && strobe;
        next_sel.pal  = hit[main_bus_pkg::reg_pal];
        next_sel.obj  = hit[main_bus_pkg::reg_obj];
        next_sel.io   = hit[main_bus_pkg::reg_io];
        next_sel.sub  = hit[main_bus_pkg::reg_sub];
        next_sel.map  = map_hit;
    end

    // Internal blocks answer in the select cycle
    assign fixed_rdy = sel.chr | sel.pal | sel.obj | sel.io | sel.map;

    assign var_rdy = (sel.rom & dec_ok)
                   | ((sel.ram | sel.vram) & ram_ok)
                   | (sel.sub & sub_ok);

    assign ready = fixed_rdy | var_rdy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel     <= '0;
            dtack_n <= 1'b1;
        end else if (req.asn) begin
            // Bus released
            sel     <= '0;
            dtack_n <= 1'b1;
        end else begin
            sel <= next_sel;
            if (ready) begin
                dtack_n <= 1'b0;   // Held until asn rises
            end
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(sel))
        else $error("more than one chip select active: %b", sel);

    // Master holds the strobe until it has seen the acknowledge
    a_asn_release: assert property (@(posedge clk) disable iff (rst)
        $rose(req.asn) |-> $past(!dtack_n))
        else $error("address strobe released before dtack_n went low");

endmodule

`default_nettype wire

// File: hw/bus_data_return.sv
// ##############################
// Read data return
//   Registered source selection
// ##############################

`timescale 1ns/1ps
`default_nettype none

module bus_data_return (
    input  wire                      clk,
    input  wire                      rst,
    input  main_bus_pkg::slave_sel_t sel,
    input  wire [15:0]               ram_data,
    input  wire [15:0]               dec_data,
    input  wire [15:0]               chr_data,
    input  wire [15:0]               pal_data,
    input  wire [15:0]               obj_data,
    input  wire [15:0]               sub_data,
    input  wire [15:0]               map_rdata,
    input  wire [7:0]                io_rdata,
    output logic [15:0]              rdata
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= 16'hffff;
        end else if (sel.ram || sel.vram) begin
            rdata <= ram_data;   // Shared SDRAM port
        end else if (sel.rom) begin
            rdata <= dec_data;
        end else if (sel.chr) begin
            rdata <= chr_data;
        end else if (sel.pal) begin
            rdata <= pal_data;
        end else if (sel.obj) begin
            rdata <= obj_data;
        end else if (sel.sub) begin
            rdata <= sub_data;
        end else if (sel.io) begin
            rdata <= {8'hff, io_rdata};   // Byte wide peripheral
        end else if (sel.map) begin
            rdata <= map_rdata;
        end else begin
            rdata <= 16'hffff;
        end
    end

endmodule

`default_nettype wire

// File: hw/cab_io.sv
// ##############################
// Cabinet I/O
//   Parallel port output latch
//   Input read multiplexer
//   Video and sound control bits
// ##############################

`timescale 1ns/1ps
`default_nettype none

module cab_io (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    io_sel,
    input  main_bus_pkg::bus_req_t req,
    input  wire [7:0]              joystick1,
    input  wire [1:0]              start_button,
    input  wire [1:0]              coin_input,
    input  wire                    service,
    input  wire                    dip_test,
    input  wire [7:0]              dipsw_a,
    input  wire [7:0]              dipsw_b,
    input  wire [7:0]              wheel,
    input  wire [7:0]              gas,
    input  wire [7:0]              brake,
    output logic [7:0]             io_rdata,
    output logic                   video_en,
    output logic [1:0]             obj_cfg,
    output logic                   snd_rstb
);

    logic [7:0] port_latch;
    logic [2:0] adc_ch;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_latch <= 8'h00;
        end else if (io_sel && !req.rnw && req.addr[6:4] == 3'd0 && !req.dsn[0]) begin
            port_latch <= req.wdata[7:0];
        end
    end

    assign adc_ch = port_latch[4:2];

    always_comb begin
        io_rdata = 8'hff;
        case (req.addr[6:4])
            3'd0: io_rdata = port_latch;
            3'd1: begin
                case (req.addr[2:1])
                    2'd0: io_rdata = {coin_input, 1'b0, joystick1[4], start_button[0],
                                      service, dip_test, 1'b1};
                    2'd1: io_rdata = 8'hff;
                    2'd2: io_rdata = dipsw_a;
                    default: io_rdata = dipsw_b;
                endcase
            end
            3'd3: begin
                case (adc_ch)
                    3'd0: io_rdata = wheel;
                    3'd1: io_rdata = gas + 8'h80;   // Pedals centred at 80
                    3'd2: io_rdata = brake + 8'h80;
                    default: io_rdata = 8'hff;
                endcase
            end
            default: io_rdata = 8'hff;
        endcase
    end

    assign obj_cfg  = port_latch[7:6];
    assign video_en = port_latch[5];
    assign snd_rstb = port_latch[0];   // Sound CPU held in reset until set

endmodule

`default_nettype wire

// File: hw/main_bus_pkg.sv
// ##############################
// Main CPU bus definitions
//   Region indices and count
//   Reset base addresses, mapper page
//   Bus request, slave select and
//   region hit types
// ##############################

`default_nettype none

package main_bus_pkg;

    localparam int region_count = 6;

    // Region indices, CSS order of the mapper
    localparam int reg_mem = 0;
    localparam int reg_scr = 1;
    localparam int reg_pal = 2;
    localparam int reg_obj = 3;
    localparam int reg_io  = 4;
    localparam int reg_sub = 5;

    // Bases for addr[23:16], entry 0 is rightmost
    localparam logic [region_count-1:0][7:0] base_reset = {
        8'h08,  // sub
        8'hc4,  // io
        8'h44,  // obj
        8'h84,  // pal
        8'h40,  // scr
        8'h00   // mem
    };

    localparam logic [7:0] mapper_page = 8'hff;

    typedef struct packed {
        logic [23:1] addr;
        logic [15:0] wdata;
        logic [1:0]  dsn;      // Upper, lower strobe
        logic        rnw;
        logic        asn;
        logic        opcode;   // Instruction fetch
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic pal;
        logic obj;
        logic io;
        logic sub;
        logic map;     // Mapper page or unmapped
    } slave_sel_t;

    typedef logic [region_count-1:0] region_hit_t;

endpackage

`default_nettype wire

// File: hw/main_bus_top.sv
// ##############################
// Main CPU bus section top
//   Mapper, bus controller,
//   decryptor, cabinet I/O and
//   read data return
// ##############################

`timescale 1ns/1ps
`default_nettype none

module main_bus_top (
    input  wire                    clk,
    input  wire                    rst,
    input  main_bus_pkg::bus_req_t req,
    output logic                   dtack_n,
    output logic [15:0]            rdata,

    // Chip selects
    output logic                   rom_cs,
    output logic                   ram_cs,
    output logic                   vram_cs,
    output logic                   chr_cs,
    output logic                   pal_cs,
    output logic                   obj_cs,
    output logic                   sub_cs,
    output logic [19:1]            addr_out,

    // Slave returns
    input  wire [15:0]             rom_data,
    input  wire                    rom_ok,
    input  wire [15:0]             ram_data,   // RAM or VRAM
    input  wire                    ram_ok,
    input  wire [15:0]             chr_data,
    input  wire [15:0]             pal_data,
    input  wire [15:0]             obj_data,
    input  wire [15:0]             sub_data,
    input  wire                    sub_ok,

    // Decryptor key load
    input  wire                    prog_we,
    input  wire [3:0]              prog_addr,
    input  wire [15:0]             prog_data,
    input  wire                    dec_en,

    // Cabinet
    input  wire [7:0]              joystick1,
    input  wire [1:0]              start_button,
    input  wire [1:0]              coin_input,
    input  wire                    service,
    input  wire                    dip_test,
    input  wire [7:0]              dipsw_a,
    input  wire [7:0]              dipsw_b,
    input  wire [7:0]              wheel,
    input  wire [7:0]              gas,
    input  wire [7:0]              brake,
    output logic                   video_en,
    output logic [1:0]             obj_cfg,
    output logic                   snd_rstb
);

    main_bus_pkg::region_hit_t hit;
    main_bus_pkg::slave_sel_t  sel;
    logic                      map_hit;
    logic [15:0]               map_rdata;
    logic [15:0]               dec_data;
    logic                      dec_ok;
    logic [7:0]                io_rdata;

    assign rom_cs   = sel.rom;
    assign ram_cs   = sel.ram;
    assign vram_cs  = sel.vram;
    assign chr_cs   = sel.chr;
    assign pal_cs   = sel.pal;
    assign obj_cs   = sel.obj;
    assign sub_cs   = sel.sub;
    assign addr_out = req.addr[19:1];

    region_mapper region_mapper_i (
        .clk(clk), .rst(rst), .req(req),
        .hit(hit), .map_hit(map_hit), .map_rdata(map_rdata)
    );

    bus_ctrl bus_ctrl_i (
        .clk(clk), .rst(rst), .req(req), .hit(hit), .map_hit(map_hit),
        .ram_ok(ram_ok), .sub_ok(sub_ok), .dec_ok(dec_ok),
        .sel(sel), .dtack_n(dtack_n)
    );

    rom_decrypt rom_decrypt_i (
        .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .dec_en(dec_en), .req(req),
        .rom_data(rom_data), .rom_ok(rom_ok), .dec_data(dec_data), .dec_ok(dec_ok)
    );

    cab_io cab_io_i (
        .clk(clk), .rst(rst), .io_sel(sel.io), .req(req),
        .joystick1(joystick1), .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .wheel(wheel), .gas(gas), .brake(brake), .io_rdata(io_rdata),
        .video_en(video_en), .obj_cfg(obj_cfg), .snd_rstb(snd_rstb)
    );

    bus_data_return bus_data_return_i (
        .clk(clk), .rst(rst), .sel(sel),
        .ram_data(ram_data), .dec_data(dec_data), .chr_data(chr_data),
        .pal_data(pal_data), .obj_data(obj_data), .sub_data(sub_data),
        .map_rdata(map_rdata), .io_rdata(io_rdata), .rdata(rdata)
    );

endmodule

`default_nettype wire

// File: hw/region_mapper.sv
// ##############################
// Region mapper
//   Six programmable base registers
//   One-hot region hit decode
//   Base register readback
// ##############################

`timescale 1ns/1ps
`default_nettype none

module region_mapper (
    input  wire                       clk,
    input  wire                       rst,
    input  main_bus_pkg::bus_req_t    req,
    output main_bus_pkg::region_hit_t hit,
    output logic                      map_hit,
    output logic [15:0]               map_rdata
);

    logic [7:0] base [main_bus_pkg::region_count];
    logic [7:0] page;
    logic [2:0] reg_idx;
    logic       idx_valid;
    logic       map_page;
    logic       map_wr;

    assign page      = req.addr[23:16];
    assign reg_idx   = req.addr[3:1];
    assign idx_valid = reg_idx < main_bus_pkg::region_count;
    assign map_page  = page == main_bus_pkg::mapper_page;

    // Only the low byte lane carries the base
    assign map_wr = !req.asn && !req.rnw && map_page && !req.dsn[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < main_bus_pkg::region_count; i++) begin
                base[i] <= main_bus_pkg::base_reset[i];
            end
        end else if (map_wr && idx_valid) begin
            base[reg_idx] <= req.wdata[7:0];
        end
    end

    // Descending scan so the lowest index wins
    always_comb begin
        hit     = '0;
        map_hit = 1'b1;
        if (!map_page) begin
            for (int i = main_bus_pkg::region_count - 1; i >= 0; i--) begin
                if (base[i] == page) begin
                    hit     = '0;
                    hit[i]  = 1'b1;
                    map_hit = 1'b0;
                end
            end
        end
    end

    // Unmapped space reads as open bus
    always_comb begin
        map_rdata = 16'hffff;
        if (map_page && idx_valid) begin
            map_rdata = {8'hff, base[reg_idx]};
        end
    end

    // Decode must not move under an access in flight
    a_hit_stable: assert property (@(posedge clk) disable iff (rst)
        !req.asn && !$past(req.asn) |-> $stable(hit))
        else $error("region hit changed during an access: %b", hit);

endmodule

`default_nettype wire

// File: hw/rom_decrypt.sv
// ##############################
// Program ROM opcode decryptor
//   Sixteen-entry key table
//   XOR on opcode fetches
//   ok delayed by one cycle
// ##############################

`timescale 1ns/1ps
`default_nettype none

module rom_decrypt (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    prog_we,
    input  wire [3:0]              prog_addr,
    input  wire [15:0]             prog_data,
    input  wire                    dec_en,
    input  main_bus_pkg::bus_req_t req,
    input  wire [15:0]             rom_data,
    input  wire                    rom_ok,
    output logic [15:0]            dec_data,
    output logic                   dec_ok
);

    logic [15:0] key_table [16];
    logic [3:0]  key_idx;
    logic [15:0] key;
    logic        op_fetch;
    logic        ok_dly;

    // Key picked by the word address inside a 16-word block
    assign key_idx  = req.addr[4:1];
    assign key      = key_table[key_idx];
    assign op_fetch = dec_en && req.opcode;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            key_table[prog_addr] <= prog_data;
        end
    end

    // Data reads and disabled decoding pass straight through
    always_ff @(posedge clk) begin
        if (op_fetch) begin
            dec_data <= rom_data ^ key;
        end else begin
            dec_data <= rom_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ok_dly <= 1'b0;
        end else begin
            ok_dly <= rom_ok;
        end
    end

    // Drops together with rom_ok, no stale ok
    assign dec_ok = ok_dly & rom_ok;

endmodule

`default_nettype wire

// File: main_bus_top.f
hw/main_bus_pkg.sv
hw/region_mapper.sv
hw/bus_ctrl.sv
hw/rom_decrypt.sv
hw/cab_io.sv
hw/bus_data_return.sv
hw/main_bus_top.sv
verification/main_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the main bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module main_bus_tb -f main_bus_top.f -o main_bus_sim

output=$(./obj_dir/main_bus_sim)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

// File: verification/main_bus_input.txt
// Bus master vectors, one operation per line: kind addr wdata expect cs
//   kind 0 read, 1 write, 2 fetch, 3 key load, 4 dec_en, 5 control outputs
//   cs bits rom ram vram chr pal obj sub; expect used by reads and kind 5
// Port latch and cabinet inputs
1 c40000 00e1 0000 00
5 000000 0000 000f 00
0 c40000 0000 ffe1 00
0 c40010 0000 ff9b 00
0 c40014 0000 ff3c 00
0 c40016 0000 ffc5 00
0 c40030 0000 ff47 00
1 c40000 0025 0000 00
5 000000 0000 0003 00
0 c40030 0000 ffa1 00
1 c40000 0028 0000 00
0 c40030 0000 ff10 00
// Default map
0 000100 0000 d080 40
0 400008 0000 5a04 10
0 840000 0000 fa11 04
0 440000 0000 0b1e 02
0 080040 0000 a585 01
0 200000 0000 ffff 00
// Character ROM, scr base moved to 41 and back
1 ff0002 0041 0000 00
0 410000 0000 c0de 08
1 ff0002 0040 0000 00
// Work RAM, mem base moved to 06 and back
1 ff0000 0006 0000 00
1 060010 1234 0000 20
1 060020 abcd 0000 20
0 060010 0000 1234 20
0 060020 0000 abcd 20
1 ff0000 0000 0000 00
0 ff0000 0000 ff00 00
// Opcode decryption
3 000003 5a5a 0000 00
3 000004 0f0f 0000 00
4 000000 0001 0000 00
2 000006 0000 8a59 40
2 000008 0000 df0b 40
0 000006 0000 d003 40
4 000000 0000 0000 00
2 000006 0000 d003 40
// Sub region moved to page 12
1 ff000a 0012 0000 00
0 ff000a 0000 ff12 00
0 120040 0000 a585 01
0 080040 0000 ffff 00

// File: verification/main_bus_tb.sv
// ##############################
// Main bus testbench
//   Clock, reset, slave models
//   Bus master driven from the
//   vector file, result checks
// ##############################

`timescale 1ns/1ps
`default_nettype none

module main_bus_tb;

    localparam int          max_ops         = 64;
    localparam int          timeout_cycles  = 100;
    localparam int          fixed_ack_waits = 3;   // Drive, select, acknowledge
    localparam logic [23:0] end_mark        = 24'hffffff;

    logic                   clk;
    logic                   rst;
    main_bus_pkg::bus_req_t req;
    logic                   dtack_n;
    logic [15:0]            rdata;
    logic                   rom_cs, ram_cs, vram_cs, chr_cs, pal_cs, obj_cs, sub_cs;
    logic [19:1]            addr_out;
    logic [15:0]            rom_data;
    logic [15:0]            ram_data;
    logic [15:0]            sub_data;
    logic                   rom_ok = 1'b0;
    logic                   ram_ok = 1'b0;
    logic                   sub_ok = 1'b0;
    logic                   prog_we;
    logic [3:0]             prog_addr;
    logic [15:0]            prog_data;
    logic                   dec_en;
    logic                   video_en;
    logic [1:0]             obj_cfg;
    logic                   snd_rstb;

    logic [15:0] ram_mem [64];
    logic [23:0] vec_mem [5 * max_ops];
    logic [31:0] seed = 32'h99f4;
    int          rom_delay = 0;
    int          ram_delay = 0;
    int          sub_delay = 0;
    int          rom_cnt = 0;
    int          ram_cnt = 0;
    int          sub_cnt = 0;
    int          errors = 0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    main_bus_top dut_i (
        .clk(clk), .rst(rst), .req(req), .dtack_n(dtack_n), .rdata(rdata),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .chr_cs(chr_cs),
        .pal_cs(pal_cs), .obj_cs(obj_cs), .sub_cs(sub_cs), .addr_out(addr_out),
        .rom_data(rom_data), .rom_ok(rom_ok), .ram_data(ram_data), .ram_ok(ram_ok),
        .chr_data(16'hc0de), .pal_data(16'hfa11), .obj_data(16'h0b1e),   // Video patterns
        .sub_data(sub_data), .sub_ok(sub_ok),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data), .dec_en(dec_en),
        // Cabinet wiring that the expected values in the vector file assume
        .joystick1(8'h10), .start_button(2'b01), .coin_input(2'b10),
        .service(1'b0), .dip_test(1'b1), .dipsw_a(8'h3c), .dipsw_b(8'hc5),
        .wheel(8'h47), .gas(8'h21), .brake(8'h90),
        .video_en(video_en), .obj_cfg(obj_cfg), .snd_rstb(snd_rstb)
    );

    // ROM word carries its own word address
    assign rom_data = {4'hd, req.addr[12:1]};
    assign sub_data = req.addr[16:1] ^ 16'ha5a5;
    // VRAM shares the RAM data port and answers with a fixed pattern
    assign ram_data = ram_cs ? ram_mem[req.addr[6:1]] : {8'h5a, req.addr[8:1]};

    // Variable latency slaves, ok held while cs stays high
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                ram_mem[i] <= 16'(i * 37) ^ 16'h3c3c;
            end
            rom_ok <= 1'b0;
            ram_ok <= 1'b0;
            sub_ok <= 1'b0;
        end else begin
            rom_ok  <= rom_cs && rom_cnt >= rom_delay;
            rom_cnt <= rom_cs ? rom_cnt + 1 : 0;
            ram_ok  <= (ram_cs || vram_cs) && ram_cnt >= ram_delay;
            ram_cnt <= (ram_cs || vram_cs) ? ram_cnt + 1 : 0;
            sub_ok  <= sub_cs && sub_cnt >= sub_delay;
            sub_cnt <= sub_cs ? sub_cnt + 1 : 0;
            if (ram_cs && ram_ok && !req.rnw) begin
                if (!req.dsn[1]) begin
                    ram_mem[req.addr[6:1]][15:8] <= req.wdata[15:8];
                end
                if (!req.dsn[0]) begin
                    ram_mem[req.addr[6:1]][7:0] <= req.wdata[7:0];
                end
            end
        end
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic string kind_name(input logic [23:0] kind);
        case (kind)
            24'h0: return "read";
            24'h1: return "write";
            24'h2: return "fetch";
            24'h3: return "key load";
            24'h4: return "dec_en";
            24'h5: return "control";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_key(input logic [3:0] idx, input logic [15:0] key);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= idx;
        prog_data <= key;
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // One full master cycle, strobe held until dtack_n
    task automatic bus_access(input logic [23:0] addr, input logic [15:0] wdata,
                              input logic rnw, input logic opcode,
                              output logic acked, output logic [15:0] data,
                              output logic [6:0] cs_seen, output int waits);
        int n;
        rom_delay = int'((next_random() >> 16) % 6);
        ram_delay = int'((next_random() >> 16) % 6);
        sub_delay = int'((next_random() >> 16) % 6);
        cs_seen = '0;
        waits   = 0;
        @(posedge clk);
        req <= '{addr: addr[23:1], wdata: wdata, dsn: 2'b00, rnw: rnw, asn: 1'b0,
                 opcode: opcode};
        do begin
            @(negedge clk);
            waits++;
            cs_seen |= {rom_cs, ram_cs, vram_cs, chr_cs, pal_cs, obj_cs, sub_cs};
        end while (dtack_n && waits < timeout_cycles);
        acked = !dtack_n;
        data  = rdata;
        if (!acked) begin
            $display("Timeout: no acknowledge for address %h within %0d cycles",
                     addr, timeout_cycles);
            errors++;
        end else if (addr_out != addr[19:1]) begin
            $display("[ERROR] %0t addr_out: got %h, expected %h", $time, addr_out, addr[19:1]);
            errors++;
        end
        @(posedge clk);
        req.asn <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dtack_n && n < timeout_cycles);
        if (!dtack_n) begin
            $display("Timeout: dtack_n stayed low after the address strobe was released");
            errors++;
        end
    endtask

    initial begin
        int          op;
        int          waits;
        int          err_before;
        logic [23:0] kind;
        logic [23:0] addr;
        logic [15:0] wdata;
        logic [15:0] exp_data;
        logic [6:0]  exp_cs;
        logic [6:0]  cs_seen;
        logic [15:0] data;
        logic        acked;

        req       <= '{addr: '0, wdata: '0, dsn: 2'b11, rnw: 1'b1, asn: 1'b1, opcode: 1'b0};
        rst       <= 1'b1;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        dec_en    <= 1'b0;
        for (int i = 0; i < 5 * max_ops; i++) begin
            vec_mem[i] = end_mark;
        end
        $readmemh("verification/main_bus_input.txt", vec_mem);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if ({rom_cs, ram_cs, vram_cs, chr_cs, pal_cs, obj_cs, sub_cs} != 7'h00) begin
            $display("[ERROR] %0t chip selects: got %b, expected 0000000", $time,
                     {rom_cs, ram_cs, vram_cs, chr_cs, pal_cs, obj_cs, sub_cs});
            errors++;
        end
        if (dtack_n != 1'b1 || video_en != 1'b0 || snd_rstb != 1'b0) begin
            $display("[ERROR] %0t dtack_n/video_en/snd_rstb: got %b%b%b, expected 100",
                     $time, dtack_n, video_en, snd_rstb);
            errors++;
        end
        $display("test reset state: %s", errors == 0 ? "ok" : "FAILED");

        op = 0;
        while (op < max_ops && vec_mem[op * 5] != end_mark) begin
            kind       = vec_mem[op * 5];
            addr       = vec_mem[op * 5 + 1];
            wdata      = vec_mem[op * 5 + 2][15:0];
            exp_data   = vec_mem[op * 5 + 3][15:0];
            exp_cs     = vec_mem[op * 5 + 4][6:0];
            err_before = errors;
            case (kind)
                24'h0, 24'h1, 24'h2: begin
                    bus_access(addr, wdata, kind != 24'h1, kind == 24'h2,
                               acked, data, cs_seen, waits);
                    if (acked && kind != 24'h1 && data != exp_data) begin
                        $display("[ERROR] %0t rdata: got %h, expected %h", $time, data, exp_data);
                        errors++;
                    end
                    if (acked && cs_seen != exp_cs) begin
                        $display("[ERROR] %0t chip selects: got %b, expected %b", $time,
                                 cs_seen, exp_cs);
                        errors++;
                    end
                    // Internal slaves: chr, pal, obj, io, mapper
                    if (acked && (exp_cs & 7'h71) == 7'h00 && waits != fixed_ack_waits) begin
                        $display("[ERROR] %0t dtack_n cycle: got %0d, expected %0d", $time,
                                 waits, fixed_ack_waits);
                        errors++;
                    end
                end
                24'h3: load_key(addr[3:0], wdata);
                24'h4: begin
                    @(posedge clk);
                    dec_en <= wdata[0];
                end
                24'h5: begin
                    @(negedge clk);
                    if ({obj_cfg, video_en, snd_rstb} != exp_data[3:0]) begin
                        $display("[ERROR] %0t obj_cfg/video_en/snd_rstb: got %b, expected %b",
                                 $time, {obj_cfg, video_en, snd_rstb}, exp_data[3:0]);
                        errors++;
                    end
                end
                default: begin
                    $display("Vector %0d has an unknown operation kind %h", op, kind);
                    errors++;
                end
            endcase
            $display("test %0d %s %h: %s", op, kind_name(kind), addr,
                     errors == err_before ? "ok" : "FAILED");
            op++;
        end

        $display("Tests run: %0d, errors: %0d", op + 1, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
